/* compile.f */
src/mc_pkg.sv
src/mc_reset_seq.sv
src/noc_mem_bridge.sv
src/mem_zeroer.sv
src/sim_mem.sv
src/mc_top.sv
sim/tb_mc_top.sv

/* Bender.yml */
package:
  name: mc_frontend

sources:
  - src/mc_pkg.sv
  - src/mc_reset_seq.sv
  - src/noc_mem_bridge.sv
  - src/mem_zeroer.sv
  - src/sim_mem.sv
  - src/mc_top.sv
  - target: simulation
    files:
      - sim/tb_mc_top.sv

/* sim/tb_mc_top.sv */
`timescale 1ns/10ps

module tb_mc_top;
  import mc_pkg::*;

  localparam int TIMEOUT_CYCLES = 2000;  // reset, ~70 zeroing cycles, tests and margin
  localparam int STALL_CYCLES   = 20;

  logic              core_ref_clk;
  logic              sys_rst_n;
  flit_u             flit_in_data_i;
  logic              flit_in_val_i;
  logic              flit_in_rdy_o;
  flit_u             flit_out_data_o;
  logic              flit_out_val_o;
  logic              flit_out_rdy_i;
  logic              mc_ui_rst_o;
  logic              init_calib_complete_o;
  logic [FLIT_W-1:0] exp_q[$];                // response flits still expected in order
  logic [FLIT_W-1:0] model_mem [MEM_WORDS];
  logic [31:0]       lfsr_q    = 32'ha5fb_4a10;
  int                err_cnt   = 0;
  int                rsp_cnt   = 0;
  int                cycle_cnt = 0;

  mc_top dut0 (.*);

  initial core_ref_clk = 1'b0;
  always #50 core_ref_clk = ~core_ref_clk;

  // fibonacci LFSR with taps 32 22 2 1
  function automatic logic [63:0] rand_bits(input int nbits);
    logic [63:0] word;
    word = '0;
    for (int i = 0; i < nbits; i++) begin
      word   = {word[62:0], lfsr_q[31]};
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
    end
    return word;
  endfunction

  function automatic logic [FLIT_W-1:0] hdr_word(input logic [MSG_W-1:0] msg,
                                                 input logic [TAG_W-1:0] tag,
                                                 input logic [MEM_AW-1:0] addr);
    flit_u f;
    f          = '0;  // reserved bits stay zero
    f.hdr.msg  = msg;
    f.hdr.tag  = tag;
    f.hdr.addr = addr;
    return f.data;
  endfunction

  task automatic report_mismatch(input string name, input logic [FLIT_W-1:0] exp_v,
                                 input logic [FLIT_W-1:0] got);
    $display("FAIL t=%0t %s expected %h got %h", $time, name, exp_v, got);
    err_cnt++;
  endtask

  task automatic report_error(input string what);
    $display("ERROR t=%0t %s", $time, what);
    err_cnt++;
  endtask

  // drive from a falling edge until the transfer completes
  task automatic push_flit(input logic [FLIT_W-1:0] word);
    flit_in_data_i = word;
    flit_in_val_i  = 1'b1;
    while (flit_in_rdy_o !== 1'b1) begin
      @(negedge core_ref_clk);
    end
    @(negedge core_ref_clk);
    flit_in_val_i = 1'b0;
  endtask

  task automatic expect_resp(input logic [MSG_W-1:0] msg, input logic [TAG_W-1:0] tag,
                             input logic [FLIT_W-1:0] data, input logic has_data);
    exp_q.push_back(hdr_word(msg, tag, '0));
    if (has_data) begin
      exp_q.push_back(data);
    end
  endtask

  task automatic send_load(input logic [TAG_W-1:0] tag, input logic [MEM_AW-1:0] addr);
    expect_resp(MSG_LOAD_ACK, tag, model_mem[addr], 1'b1);
    push_flit(hdr_word(MSG_LOAD, tag, addr));
  endtask

  task automatic send_store(input logic [TAG_W-1:0] tag, input logic [MEM_AW-1:0] addr,
                            input logic [FLIT_W-1:0] data);
    model_mem[addr] = data;
    expect_resp(MSG_STORE_ACK, tag, '0, 1'b0);
    push_flit(hdr_word(MSG_STORE, tag, addr));
    push_flit(data);
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(negedge core_ref_clk);
    end
  endtask

  // compare each accepted response flit in order
  always @(posedge core_ref_clk) begin
    if (flit_out_val_o && flit_out_rdy_i) begin
      rsp_cnt++;
      if (exp_q.size() == 0) begin
        report_error("response flit arrived with no request outstanding");
      end else if (flit_out_data_o !== exp_q[0]) begin
        report_mismatch("flit_out_data_o", exp_q.pop_front(), flit_out_data_o);
      end else begin
        void'(exp_q.pop_front());
      end
    end
  end

  task automatic reset_sequence();
    sys_rst_n = 1'b0;
    repeat (4) begin
      @(negedge core_ref_clk);
      if (mc_ui_rst_o !== 1'b1) report_mismatch("mc_ui_rst_o", 1'b1, mc_ui_rst_o);
    end
    sys_rst_n = 1'b1;
    for (int i = 1; i <= RST_DELAY + 1; i++) begin
      @(negedge core_ref_clk);
      if (mc_ui_rst_o !== (i <= RST_DELAY)) begin
        report_mismatch("mc_ui_rst_o", (i <= RST_DELAY), mc_ui_rst_o);
      end
      if (init_calib_complete_o !== 1'b0) begin
        report_mismatch("init_calib_complete_o", 1'b0, init_calib_complete_o);
      end
      if (flit_in_rdy_o !== 1'b0) report_mismatch("flit_in_rdy_o", 1'b0, flit_in_rdy_o);
    end
    while (init_calib_complete_o !== 1'b1) begin  // zeroing in progress
      if (flit_in_rdy_o !== 1'b0) report_mismatch("flit_in_rdy_o", 1'b0, flit_in_rdy_o);
      @(negedge core_ref_clk);
    end
  endtask

  task automatic zeroed_loads();
    send_load(8'h01, 6'd0);
    send_load(8'h02, 6'd21);
    send_load(8'h03, 6'd42);
    send_load(8'h04, 6'd63);
    wait_drained();
  endtask

  task automatic store_load_pairs();
    logic [MEM_AW-1:0] addrs [4];
    for (int i = 0; i < 4; i++) begin
      addrs[i] = MEM_AW'(rand_bits(MEM_AW));
      send_store(TAG_W'(8'h10 + i), addrs[i], rand_bits(FLIT_W));
    end
    for (int i = 0; i < 4; i++) begin
      send_load(TAG_W'(8'h20 + i), addrs[i]);
    end
    wait_drained();
  endtask

  task automatic ordered_burst();
    send_store(8'h31, 6'd5, rand_bits(FLIT_W));
    send_load(8'h32, 6'd5);
    send_store(8'h33, 6'd6, rand_bits(FLIT_W));
    send_load(8'h34, 6'd6);
    wait_drained();
  endtask

  // stall the output and watch the held flit
  task automatic hold_output(input int cycles);
    logic [FLIT_W-1:0] held;
    logic              held_val;
    held           = '0;
    held_val       = 1'b0;
    flit_out_rdy_i = 1'b0;
    repeat (cycles) begin
      @(negedge core_ref_clk);
      if (held_val) begin
        if (flit_out_val_o !== 1'b1) report_mismatch("flit_out_val_o", 1'b1, flit_out_val_o);
        if (flit_out_data_o !== held) report_mismatch("flit_out_data_o", held, flit_out_data_o);
      end else if (flit_out_val_o) begin
        held     = flit_out_data_o;
        held_val = 1'b1;
      end
    end
    if (flit_in_rdy_o !== 1'b0) begin
      report_mismatch("flit_in_rdy_o", 1'b0, flit_in_rdy_o);  // input must have backed up
    end
    flit_out_rdy_i = 1'b1;
    if (!held_val) report_error("no response flit appeared during output stall");
  endtask

  task automatic backpressure_burst();
    fork
      begin
        send_load(8'h41, 6'd5);
        send_store(8'h42, 6'd9, rand_bits(FLIT_W));
        send_load(8'h43, 6'd9);
        send_load(8'h44, 6'd6);
      end
      hold_output(STALL_CYCLES);
    join
    wait_drained();
  endtask

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge core_ref_clk);
      cycle_cnt++;
    end
    $display("ERROR timeout after %0d cycles, %0d response flits missing, %0d errors",
             cycle_cnt, exp_q.size(), err_cnt);
    $display("Checks failed");
    $finish;
  end

  initial begin
    sys_rst_n      = 1'b0;
    flit_in_data_i = '0;
    flit_in_val_i  = 1'b0;
    flit_out_rdy_i = 1'b1;
    foreach (model_mem[i]) begin
      model_mem[i] = '0;  // zeroer clears every word
    end
    reset_sequence();
    zeroed_loads();
    store_load_pairs();
    ordered_burst();
    backpressure_burst();
    repeat (5) @(negedge core_ref_clk);  // room for stray flits
    $display("summary: %0d response flits, %0d errors", rsp_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* src/mc_top.sv */
`timescale 1ns/10ps

module mc_top (
  input  logic          core_ref_clk,
  input  logic          sys_rst_n,
  input  mc_pkg::flit_u flit_in_data_i,
  input  logic          flit_in_val_i,
  output logic          flit_in_rdy_o,
  output mc_pkg::flit_u flit_out_data_o,
  output logic          flit_out_val_o,
  input  logic          flit_out_rdy_i,
  output logic          mc_ui_rst_o,
  output logic          init_calib_complete_o
);
  import mc_pkg::*;

  logic     bridge_rst;  // delayed reset for bridge, zeroer and memory
  logic     zero_done;
  mem_req_t br_req;
  logic     br_req_val;
  logic     br_req_rdy;
  mem_rsp_t br_rsp;
  logic     br_rsp_val;
  logic     br_rsp_rdy;
  mem_req_t mem_req;
  logic     mem_req_val;
  logic     mem_req_rdy;
  mem_rsp_t mem_rsp;
  logic     mem_rsp_val;
  logic     mem_rsp_rdy;

  mc_reset_seq u_reset_seq (
    .core_ref_clk,
    .sys_rst_n,
    .zero_done_i           (zero_done),
    .bridge_rst_o          (bridge_rst),
    .mc_ui_rst_o,
    .init_calib_complete_o
  );

  noc_mem_bridge u_bridge (
    .core_ref_clk,
    .rst_i          (bridge_rst),
    .init_done_i    (init_calib_complete_o),
    .flit_in_data_i,
    .flit_in_val_i,
    .flit_in_rdy_o,
    .flit_out_data_o,
    .flit_out_val_o,
    .flit_out_rdy_i,
    .mem_req_o      (br_req),
    .mem_req_val_o  (br_req_val),
    .mem_req_rdy_i  (br_req_rdy),
    .mem_rsp_i      (br_rsp),
    .mem_rsp_val_i  (br_rsp_val),
    .mem_rsp_rdy_o  (br_rsp_rdy)
  );

  mem_zeroer u_zeroer (
    .core_ref_clk,
    .rst_i        (bridge_rst),
    .up_req_i     (br_req),
    .up_req_val_i (br_req_val),
    .up_req_rdy_o (br_req_rdy),
    .up_rsp_o     (br_rsp),
    .up_rsp_val_o (br_rsp_val),
    .up_rsp_rdy_i (br_rsp_rdy),
    .dn_req_o     (mem_req),
    .dn_req_val_o (mem_req_val),
    .dn_req_rdy_i (mem_req_rdy),
    .dn_rsp_i     (mem_rsp),
    .dn_rsp_val_i (mem_rsp_val),
    .dn_rsp_rdy_o (mem_rsp_rdy),
    .zero_done_o  (zero_done)
  );

  sim_mem u_mem (
    .core_ref_clk,
    .req_i     (mem_req),
    .req_val_i (mem_req_val),
    .req_rdy_o (mem_req_rdy),
    .rsp_o     (mem_rsp),
    .rsp_val_o (mem_rsp_val),
    .rsp_rdy_i (mem_rsp_rdy),
    .rst_i     (bridge_rst)
  );

endmodule

/* src/sim_mem.sv */
`timescale 1ns/10ps

module sim_mem (
  input  logic             core_ref_clk,
  input  mc_pkg::mem_req_t req_i,
  input  logic             req_val_i,
  output logic             req_rdy_o,
  output mc_pkg::mem_rsp_t rsp_o,
  output logic             rsp_val_o,
  input  logic             rsp_rdy_i,
  input  logic             rst_i
);
  import mc_pkg::*;

  logic [FLIT_W-1:0]      mem_q [MEM_WORDS];
  logic [MEM_LATENCY-1:0] stg_val_q;
  mem_rsp_t               stg_rsp_q [MEM_LATENCY];
  mem_rsp_t               new_rsp;
  logic                   advance;
  logic                   req_fire;

  // whole pipeline moves only when the last stage is empty or taken
  assign advance   = !stg_val_q[MEM_LATENCY-1] || rsp_rdy_i;
  assign req_rdy_o = advance;
  assign req_fire  = req_val_i && req_rdy_o;

  always_comb begin
    new_rsp.we    = req_i.we;
    new_rsp.rdata = req_i.we ? '0 : mem_q[req_i.addr];  // read at acceptance
    new_rsp.tag   = req_i.tag;
  end

  always_ff @(posedge core_ref_clk) begin
    if (req_fire && req_i.we) begin
      mem_q[req_i.addr] <= req_i.wdata;
    end
  end

  always_ff @(posedge core_ref_clk) begin
    if (rst_i) begin
      stg_val_q <= '0;
    end else if (advance) begin
      stg_val_q[0] <= req_fire;
      for (int i = 1; i < MEM_LATENCY; i++) begin
        stg_val_q[i] <= stg_val_q[i-1];
      end
    end
  end

  always_ff @(posedge core_ref_clk) begin
    if (advance) begin
      stg_rsp_q[0] <= new_rsp;
      for (int i = 1; i < MEM_LATENCY; i++) begin
        stg_rsp_q[i] <= stg_rsp_q[i-1];
      end
    end
  end

  assign rsp_o     = stg_rsp_q[MEM_LATENCY-1];
  assign rsp_val_o = stg_val_q[MEM_LATENCY-1];

endmodule

/* src/mem_zeroer.sv */
`timescale 1ns/10ps

module mem_zeroer (
  input  logic             core_ref_clk,
  input  logic             rst_i,
  input  mc_pkg::mem_req_t up_req_i,
  input  logic             up_req_val_i,
  output logic             up_req_rdy_o,
  output mc_pkg::mem_rsp_t up_rsp_o,
  output logic             up_rsp_val_o,
  input  logic             up_rsp_rdy_i,
  output mc_pkg::mem_req_t dn_req_o,
  output logic             dn_req_val_o,
  input  logic             dn_req_rdy_i,
  input  mc_pkg::mem_rsp_t dn_rsp_i,
  input  logic             dn_rsp_val_i,
  output logic             dn_rsp_rdy_o,
  output logic             zero_done_o
);
  import mc_pkg::*;

  typedef enum logic [1:0] {ZR_IDLE, ZR_CLEAR, ZR_PASS} zr_state_e;

  zr_state_e       state_q;
  logic [MEM_AW:0] wr_cnt_q;   // zero writes issued
  logic [MEM_AW:0] ack_cnt_q;  // zero writes acknowledged
  mem_req_t        clr_req;
  logic            clr_req_val;
  logic            clr_req_fire;
  logic            clr_rsp_fire;
  logic            last_ack;

  assign clr_req_val  = (state_q == ZR_CLEAR) && (wr_cnt_q != (MEM_AW + 1)'(MEM_WORDS));
  assign clr_req_fire = clr_req_val && dn_req_rdy_i;
  assign clr_rsp_fire = (state_q == ZR_CLEAR) && dn_rsp_val_i;
  assign last_ack     = (ack_cnt_q == (MEM_AW + 1)'(MEM_WORDS - 1));

  always_comb begin
    clr_req      = '0;
    clr_req.we   = 1'b1;
    clr_req.addr = wr_cnt_q[MEM_AW-1:0];
  end

  always_ff @(posedge core_ref_clk) begin
    if (rst_i) begin
      state_q   <= ZR_IDLE;
      wr_cnt_q  <= '0;
      ack_cnt_q <= '0;
    end else begin
      case (state_q)
        ZR_IDLE: state_q <= ZR_CLEAR;  // first cycle out of reset
        ZR_CLEAR: begin
          if (clr_req_fire) begin
            wr_cnt_q <= wr_cnt_q + 1'b1;
          end
          if (clr_rsp_fire) begin
            ack_cnt_q <= ack_cnt_q + 1'b1;
            if (last_ack) begin
              state_q <= ZR_PASS;
            end
          end
        end
        default: state_q <= state_q;  // pass-through until next reset
      endcase
    end
  end

  assign zero_done_o = (state_q == ZR_PASS);

  assign dn_req_o     = zero_done_o ? up_req_i : clr_req;
  assign dn_req_val_o = zero_done_o ? up_req_val_i : clr_req_val;
  assign up_req_rdy_o = zero_done_o && dn_req_rdy_i;
  assign up_rsp_o     = dn_rsp_i;
  assign up_rsp_val_o = zero_done_o && dn_rsp_val_i;  // zero write acks are absorbed
  assign dn_rsp_rdy_o = zero_done_o ? up_rsp_rdy_i : (state_q == ZR_CLEAR);

  // the bridge must hold off until calibration complete comes back to it
  assert property (@(posedge core_ref_clk) disable iff (rst_i)
    !zero_done_o |-> !up_req_val_i)
    else $error("upstream request raised before zeroing finished");

endmodule

/* src/noc_mem_bridge.sv */
`timescale 1ns/10ps

module noc_mem_bridge (
  input  logic             core_ref_clk,
  input  logic             rst_i,
  input  logic             init_done_i,
  input  mc_pkg::flit_u    flit_in_data_i,
  input  logic             flit_in_val_i,
  output logic             flit_in_rdy_o,
  output mc_pkg::flit_u    flit_out_data_o,
  output logic             flit_out_val_o,
  input  logic             flit_out_rdy_i,
  output mc_pkg::mem_req_t mem_req_o,
  output logic             mem_req_val_o,
  input  logic             mem_req_rdy_i,
  input  mc_pkg::mem_rsp_t mem_rsp_i,
  input  logic             mem_rsp_val_i,
  output logic             mem_rsp_rdy_o
);
  import mc_pkg::*;

  typedef enum logic [1:0] {IN_HDR, IN_DATA, IN_REQ} in_state_e;
  typedef enum logic [1:0] {OUT_IDLE, OUT_HDR, OUT_DATA} out_state_e;

  in_state_e              in_state_q;
  out_state_e             out_state_q;
  mem_req_t               req_q;
  mem_rsp_t               rsp_q;
  logic [IN_FLIGHT_W-1:0] in_flight_q;
  logic                   flit_in_fire;
  logic                   flit_out_fire;
  logic                   req_fire;
  logic                   rsp_fire;

  // new headers only while below the in-flight limit
  assign flit_in_rdy_o = init_done_i &&
                         ((in_state_q == IN_HDR &&
                           in_flight_q < IN_FLIGHT_W'(IN_FLIGHT_MAX)) ||
                          in_state_q == IN_DATA);
  assign flit_in_fire  = flit_in_val_i && flit_in_rdy_o;

  always_ff @(posedge core_ref_clk) begin
    if (rst_i) begin
      in_state_q <= IN_HDR;
    end else begin
      case (in_state_q)
        IN_HDR: begin
          if (flit_in_fire) begin
            // anything other than a store is served as a load
            in_state_q <= (flit_in_data_i.hdr.msg == MSG_STORE) ? IN_DATA : IN_REQ;
          end
        end
        IN_DATA: begin
          if (flit_in_fire) begin
            in_state_q <= IN_REQ;
          end
        end
        IN_REQ: begin
          if (req_fire) begin
            in_state_q <= IN_HDR;
          end
        end
        default: in_state_q <= IN_HDR;
      endcase
    end
  end

  always_ff @(posedge core_ref_clk) begin
    if (flit_in_fire) begin
      if (in_state_q == IN_HDR) begin
        req_q.we    <= (flit_in_data_i.hdr.msg == MSG_STORE);
        req_q.addr  <= flit_in_data_i.hdr.addr;
        req_q.tag   <= flit_in_data_i.hdr.tag;  // NoC tag rides through memory
        req_q.wdata <= '0;
      end else begin
        req_q.wdata <= flit_in_data_i.data;  // store payload flit
      end
    end
  end

  assign mem_req_o     = req_q;
  assign mem_req_val_o = (in_state_q == IN_REQ);
  assign req_fire      = mem_req_val_o && mem_req_rdy_i;

  // outstanding count, retired when the response reaches the output FSM
  always_ff @(posedge core_ref_clk) begin
    if (rst_i) begin
      in_flight_q <= '0;
    end else begin
      case ({req_fire, rsp_fire})
        2'b10:   in_flight_q <= in_flight_q + 1'b1;
        2'b01:   in_flight_q <= in_flight_q - 1'b1;
        default: in_flight_q <= in_flight_q;
      endcase
    end
  end

  assign mem_rsp_rdy_o  = (out_state_q == OUT_IDLE);
  assign rsp_fire       = mem_rsp_val_i && mem_rsp_rdy_o;
  assign flit_out_val_o = (out_state_q != OUT_IDLE);
  assign flit_out_fire  = flit_out_val_o && flit_out_rdy_i;

  always_ff @(posedge core_ref_clk) begin
    if (rst_i) begin
      out_state_q <= OUT_IDLE;
    end else begin
      case (out_state_q)
        OUT_IDLE: begin
          if (rsp_fire) begin
            out_state_q <= OUT_HDR;
          end
        end
        OUT_HDR: begin
          if (flit_out_fire) begin
            out_state_q <= rsp_q.we ? OUT_IDLE : OUT_DATA;  // loads add a data flit
          end
        end
        OUT_DATA: begin
          if (flit_out_fire) begin
            out_state_q <= OUT_IDLE;
          end
        end
        default: out_state_q <= OUT_IDLE;
      endcase
    end
  end

  always_ff @(posedge core_ref_clk) begin
    if (rsp_fire) begin
      rsp_q <= mem_rsp_i;
    end
  end

  always_comb begin
    flit_out_data_o = '0;
    if (out_state_q == OUT_DATA) begin
      flit_out_data_o.data = rsp_q.rdata;
    end else begin
      flit_out_data_o.hdr.msg = rsp_q.we ? MSG_STORE_ACK : MSG_LOAD_ACK;
      flit_out_data_o.hdr.tag = rsp_q.tag;
    end
  end

  assert property (@(posedge core_ref_clk) disable iff (rst_i)
    in_flight_q <= IN_FLIGHT_W'(IN_FLIGHT_MAX))
    else $error("in-flight count %0d above limit", in_flight_q);

endmodule

/* src/mc_reset_seq.sv */
`timescale 1ns/10ps

module mc_reset_seq (
  input  logic core_ref_clk,
  input  logic sys_rst_n,
  input  logic zero_done_i,
  output logic bridge_rst_o,
  output logic mc_ui_rst_o,
  output logic init_calib_complete_o
);
  import mc_pkg::*;

  logic [RST_CNT_W-1:0] delay_cnt_q;
  logic                 rst_delayed_q;

  // hold the bridge in reset for RST_DELAY cycles past sys_rst_n release
  always_ff @(posedge core_ref_clk) begin
    if (!sys_rst_n) begin
      delay_cnt_q   <= RST_CNT_W'(RST_DELAY);
      rst_delayed_q <= 1'b1;
    end else begin
      if (delay_cnt_q != '0) begin
        delay_cnt_q <= delay_cnt_q - 1'b1;  // count down to release
      end
      rst_delayed_q <= (delay_cnt_q != '0);
    end
  end

  assign bridge_rst_o = rst_delayed_q;
  assign mc_ui_rst_o  = rst_delayed_q;  // exported user reset

  // calibration is modelled as done at release, so zeroing is the last step
  assign init_calib_complete_o = zero_done_i & ~rst_delayed_q;

  // zeroer is reset by the delayed reset, so neither flag can be up during it
  assert property (@(posedge core_ref_clk) disable iff (!sys_rst_n)
    bridge_rst_o |-> !(init_calib_complete_o || zero_done_i))
    else $error("calibration complete seen while bridge held in reset");

endmodule

/* src/mc_pkg.sv */
package mc_pkg;

  // sizes
  localparam int FLIT_W    = 64;
  localparam int MEM_AW    = 6;
  localparam int MEM_WORDS = 64;
  localparam int TAG_W     = 8;
  localparam int MSG_W     = 4;
  localparam int HDR_RSV_W = FLIT_W - MSG_W - TAG_W - MEM_AW;  // 46 spare header bits

  // timing and limits
  localparam int RST_DELAY     = 16;
  localparam int RST_CNT_W     = $clog2(RST_DELAY + 1);
  localparam int IN_FLIGHT_MAX = 2;
  localparam int IN_FLIGHT_W   = $clog2(IN_FLIGHT_MAX + 1);
  localparam int MEM_LATENCY   = 2;  // response pipeline depth

  // message codes
  localparam logic [MSG_W-1:0] MSG_LOAD      = 4'd1;
  localparam logic [MSG_W-1:0] MSG_STORE     = 4'd2;
  localparam logic [MSG_W-1:0] MSG_LOAD_ACK  = 4'd9;
  localparam logic [MSG_W-1:0] MSG_STORE_ACK = 4'd10;

  typedef struct packed {
    logic [MSG_W-1:0]     msg;
    logic [TAG_W-1:0]     tag;
    logic [HDR_RSV_W-1:0] reserved;
    logic [MEM_AW-1:0]    addr;  // word address in the low bits
  } flit_hdr_t;

  // header and data flits share the same NoC port
  typedef union packed {
    flit_hdr_t         hdr;
    logic [FLIT_W-1:0] data;
  } flit_u;

  // one request channel, write address and data merged
  typedef struct packed {
    logic              we;
    logic [MEM_AW-1:0] addr;
    logic [FLIT_W-1:0] wdata;
    logic [TAG_W-1:0]  tag;
  } mem_req_t;

  typedef struct packed {
    logic              we;     // echoes the request kind
    logic [FLIT_W-1:0] rdata;
    logic [TAG_W-1:0]  tag;
  } mem_rsp_t;

endpackage
